// File: src/aurora_pkg.sv
package aurora_pkg;

   // Widths and sizes shared by the whole bridge
   localparam int data_w      = 32; // Stream and register data width
   localparam int axi_addr_w  = 6;  // Register bus byte address width
   localparam int frame_cnt_w = 64; // Each frame counter
   localparam int loop_depth  = 16; // Loopback FIFO entries
   localparam int loop_ptr_w  = $clog2(loop_depth);

   // One stream beat, ready travels on its own wire
   typedef struct packed {
      logic              valid;
      logic [data_w-1:0] data;
      logic              last;
   } axis_beat_t;

   // Control register, loopback sits in bit 0
   typedef struct packed {
      logic strip_en; // Drop trailing sequence word on receive
      logic loopback; // Send received frames straight back out
   } ctrl_t;

   // Register word addresses, byte address bits 5 to 2
   typedef enum logic [3:0] {
      STAT       = 4'd0,
      CTRL       = 4'd1,
      CNTR_IN_L  = 4'd2,
      CNTR_IN_H  = 4'd3,
      CNTR_OUT_H = 4'd6,
      CNTR_OUT_L = 4'd7
   } reg_addr_e;

   // Sequence appender FSM
   typedef enum logic {
      DATA,    // Forwarding user beats
      TRAILER  // Presenting the sequence word
   } append_state_e;

endpackage

// File: src/axi_lite_regs.sv
`timescale 1ns/1ps

module axi_lite_regs (
   input  logic                               usr_clk,
   input  logic                               S_AXI_ARESETN,
   input  logic [aurora_pkg::axi_addr_w-1:0]  S_AXI_AWADDR,
   input  logic                               S_AXI_AWVALID,
   output logic                               S_AXI_AWREADY,
   input  logic [aurora_pkg::data_w-1:0]      S_AXI_WDATA,
   input  logic                               S_AXI_WVALID,
   output logic                               S_AXI_WREADY,
   output logic                               S_AXI_BVALID,
   input  logic                               S_AXI_BREADY,
   input  logic [aurora_pkg::axi_addr_w-1:0]  S_AXI_ARADDR,
   input  logic                               S_AXI_ARVALID,
   output logic                               S_AXI_ARREADY,
   output logic [aurora_pkg::data_w-1:0]      S_AXI_RDATA,
   output logic                               S_AXI_RVALID,
   input  logic                               S_AXI_RREADY,
   input  aurora_pkg::axis_beat_t             link_rx,
   input  aurora_pkg::axis_beat_t             link_tx,
   input  logic                               link_tx_ready,
   input  logic                               channel_up,
   input  logic                               fifo_overflow,
   output aurora_pkg::ctrl_t                  ctrl
);
   import aurora_pkg::*;

   logic [axi_addr_w-1:0]  aw_addr;   // Address captured at write accept
   logic                   wr_accept;
   logic                   wr_en;
   logic                   rd_accept;
   logic [frame_cnt_w-1:0] cnt_in;    // Frames seen on link receive
   logic [frame_cnt_w-1:0] cnt_out;   // Frames sent on link transmit

   // Take a write only with both channels valid and no response pending
   assign wr_accept = !S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && !S_AXI_BVALID;
   assign wr_en     = S_AXI_AWVALID && S_AXI_WVALID && S_AXI_AWREADY && S_AXI_WREADY;
   assign rd_accept = !S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_AWREADY <= 1'b0;
         S_AXI_WREADY  <= 1'b0;
      end else begin
         S_AXI_AWREADY <= wr_accept; // One-cycle pulse
         S_AXI_WREADY  <= wr_accept;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (wr_accept) begin
         aw_addr <= S_AXI_AWADDR;
      end
   end

   // Control bits, only CTRL is writable
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         ctrl.loopback <= 1'b0;
         ctrl.strip_en <= 1'b1; // Strip by default
      end else if (wr_en && reg_addr_e'(aw_addr[axi_addr_w-1:2]) == CTRL) begin
         ctrl <= ctrl_t'(S_AXI_WDATA[1:0]);
      end
   end

   // Write response
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_BVALID <= 1'b0;
      end else if (wr_en) begin
         S_AXI_BVALID <= 1'b1;
      end else if (S_AXI_BREADY) begin
         S_AXI_BVALID <= 1'b0; // Held until the master takes it
      end
   end

   // Read handshake, data ready together with RVALID
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         S_AXI_ARREADY <= 1'b0;
         S_AXI_RVALID  <= 1'b0;
      end else begin
         S_AXI_ARREADY <= rd_accept;
         if (rd_accept) begin
            S_AXI_RVALID <= 1'b1;
         end else if (S_AXI_RREADY) begin
            S_AXI_RVALID <= 1'b0;
         end
      end
   end

   // Read mux, decoded straight from ARADDR
   always_ff @(posedge usr_clk) begin
      if (rd_accept) begin
         case (reg_addr_e'(S_AXI_ARADDR[axi_addr_w-1:2]))
            STAT:       S_AXI_RDATA <= {{(data_w-2){1'b0}}, fifo_overflow, channel_up};
            CTRL:       S_AXI_RDATA <= {{(data_w-2){1'b0}}, ctrl};
            CNTR_IN_L:  S_AXI_RDATA <= cnt_in[data_w-1:0];
            CNTR_IN_H:  S_AXI_RDATA <= cnt_in[frame_cnt_w-1:data_w];
            CNTR_OUT_H: S_AXI_RDATA <= cnt_out[frame_cnt_w-1:data_w];
            CNTR_OUT_L: S_AXI_RDATA <= cnt_out[data_w-1:0];
            default:    S_AXI_RDATA <= '0; // Unmapped
         endcase
      end
   end

   // Frame counters, one count per last beat
   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         cnt_in  <= '0;
         cnt_out <= '0;
      end else begin
         if (link_rx.valid && link_rx.last) begin
            cnt_in <= cnt_in + 1'b1;
         end
         if (link_tx.valid && link_tx_ready && link_tx.last) begin
            cnt_out <= cnt_out + 1'b1; // Only accepted beats
         end
      end
   end

   // A read response always follows an address request
   rvalid_after_arvalid: assert property (@(posedge usr_clk) disable iff (!S_AXI_ARESETN)
      $rose(S_AXI_RVALID) |-> $past(S_AXI_ARVALID));

   // Write response is not withdrawn
   bvalid_held: assert property (@(posedge usr_clk) disable iff (!S_AXI_ARESETN)
      S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

endmodule

// File: src/seq_appender.sv
`timescale 1ns/1ps

module seq_appender (
   input  logic                   usr_clk,
   input  logic                   S_AXI_ARESETN,
   input  aurora_pkg::axis_beat_t s_axis,
   output logic                   s_axis_ready,
   output aurora_pkg::axis_beat_t app_tx,
   input  logic                   app_ready
);
   import aurora_pkg::*;

   append_state_e     state;
   logic [data_w-1:0] seq_num; // Number carried by the next trailer

   // Data beats go through untouched except last
   always_comb begin
      if (state == TRAILER) begin
         app_tx.valid = 1'b1;
         app_tx.data  = seq_num;
         app_tx.last  = 1'b1; // Trailer closes the frame
         s_axis_ready = 1'b0; // User waits behind the trailer
      end else begin
         app_tx.valid = s_axis.valid;
         app_tx.data  = s_axis.data;
         app_tx.last  = 1'b0;
         s_axis_ready = app_ready;
      end
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         state   <= DATA;
         seq_num <= '0;
      end else begin
         case (state)
            DATA: begin
               if (s_axis.valid && app_ready && s_axis.last) begin
                  state <= TRAILER; // End of user frame
               end
            end
            TRAILER: begin
               if (app_ready) begin
                  state   <= DATA;
                  seq_num <= seq_num + 1'b1; // Count accepted trailers
               end
            end
            default: state <= DATA;
         endcase
      end
   end

   // Stalled beat stays put, relies on the user source and the path select
   app_tx_stable: assert property (@(posedge usr_clk) disable iff (!S_AXI_ARESETN)
      app_tx.valid && !app_ready |=> $stable(app_tx));

endmodule

// File: src/seq_stripper.sv
`timescale 1ns/1ps

module seq_stripper (
   input  logic                   usr_clk,
   input  logic                   S_AXI_ARESETN,
   input  aurora_pkg::axis_beat_t link_rx,
   input  logic                   strip_en,
   output aurora_pkg::axis_beat_t m_axis
);
   import aurora_pkg::*;

   logic              in_frame;  // A beat of the current frame already seen
   logic              strip_cur; // strip_en as sampled at frame start
   logic              strip_eff;
   logic              have_held; // hold_data is a pending beat
   logic [data_w-1:0] hold_data;

   // Mode is fixed at the first beat
   assign strip_eff = in_frame ? strip_cur : strip_en;

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         in_frame  <= 1'b0;
         strip_cur <= 1'b1;
         have_held <= 1'b0;
         m_axis    <= '0;
      end else begin
         m_axis.valid <= 1'b0; // Default idle
         if (link_rx.valid) begin
            in_frame  <= !link_rx.last;
            strip_cur <= strip_eff;
            if (strip_eff) begin
               // Release the previous beat one step behind
               m_axis.valid <= have_held;
               m_axis.data  <= hold_data;
               m_axis.last  <= link_rx.last;
               if (link_rx.last) begin
                  have_held <= 1'b0; // Sequence word discarded
               end else begin
                  have_held <= 1'b1;
               end
            end else begin
               m_axis <= link_rx; // Plain one-cycle register
            end
         end
      end
   end

   // Held payload, no reset
   always_ff @(posedge usr_clk) begin
      if (link_rx.valid && strip_eff && !link_rx.last) begin
         hold_data <= link_rx.data;
      end
   end

endmodule

// File: src/loop_fifo.sv
`timescale 1ns/1ps

module loop_fifo (
   input  logic                   usr_clk,
   input  logic                   S_AXI_ARESETN,
   input  logic                   wr_en,
   input  aurora_pkg::axis_beat_t link_rx,
   output aurora_pkg::axis_beat_t loop_tx,
   input  logic                   loop_ready,
   output logic                   fifo_overflow
);
   import aurora_pkg::*;

   logic [data_w:0]     mem [loop_depth]; // {last, data}
   logic [loop_ptr_w:0] wr_ptr;           // Extra bit tells full from empty
   logic [loop_ptr_w:0] rd_ptr;
   logic [loop_ptr_w:0] level;
   logic                empty;
   logic                full;
   logic                push;
   logic                pop;

   assign empty = wr_ptr == rd_ptr;
   assign full  = (wr_ptr[loop_ptr_w] != rd_ptr[loop_ptr_w]) &&
                  (wr_ptr[loop_ptr_w-1:0] == rd_ptr[loop_ptr_w-1:0]);
   assign level = wr_ptr - rd_ptr;
   assign push  = wr_en && link_rx.valid;
   assign pop   = loop_tx.valid && loop_ready;

   // Head beat shown combinationally
   assign loop_tx.valid = !empty;
   assign loop_tx.data  = mem[rd_ptr[loop_ptr_w-1:0]][data_w-1:0];
   assign loop_tx.last  = mem[rd_ptr[loop_ptr_w-1:0]][data_w];

   always_ff @(posedge usr_clk) begin
      if (push && !full) begin
         mem[wr_ptr[loop_ptr_w-1:0]] <= {link_rx.last, link_rx.data};
      end
   end

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         fifo_overflow <= 1'b0;
      end else begin
         if (push && !full) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (push && full) begin
            fifo_overflow <= 1'b1; // Beat lost, sticky
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // Read pointer never overtakes the write pointer
   no_pop_empty: assert property (@(posedge usr_clk) disable iff (!S_AXI_ARESETN)
      level <= loop_depth);

endmodule

// File: src/tx_path_select.sv
`timescale 1ns/1ps

module tx_path_select (
   input  logic                   usr_clk,
   input  logic                   S_AXI_ARESETN,
   input  logic                   loopback,
   input  aurora_pkg::axis_beat_t app_tx,
   output logic                   app_ready,
   input  aurora_pkg::axis_beat_t loop_tx,
   output logic                   loop_ready,
   output aurora_pkg::axis_beat_t link_tx,
   input  logic                   link_tx_ready
);
   import aurora_pkg::*;

   logic sel_loop;   // Registered path choice
   logic frame_open; // Accepted beats of an unfinished frame
   logic link_idle;
   logic frame_end;

   assign link_idle = !frame_open && !link_tx.valid;
   assign frame_end = link_tx.valid && link_tx_ready && link_tx.last;

   // Data path stays combinational
   assign link_tx    = sel_loop ? loop_tx : app_tx;
   assign app_ready  = !sel_loop && link_tx_ready;
   assign loop_ready = sel_loop && link_tx_ready; // Unselected side sees ready low

   always_ff @(posedge usr_clk) begin
      if (!S_AXI_ARESETN) begin
         sel_loop   <= 1'b0;
         frame_open <= 1'b0;
      end else begin
         if (link_tx.valid && link_tx_ready) begin
            frame_open <= !link_tx.last;
         end
         if (link_idle || frame_end) begin
            sel_loop <= loopback; // Switch only between frames
         end
      end
   end

endmodule

// File: src/rtds_aurora_bridge.sv
`timescale 1ns/1ps

module rtds_aurora_bridge (
   input  logic                               usr_clk,
   input  logic                               S_AXI_ARESETN,
   input  aurora_pkg::axis_beat_t             s_axis,
   output logic                               s_axis_ready,
   output aurora_pkg::axis_beat_t             m_axis,
   output aurora_pkg::axis_beat_t             link_tx,
   input  logic                               link_tx_ready,
   input  aurora_pkg::axis_beat_t             link_rx,
   input  logic                               channel_up,
   input  logic [aurora_pkg::axi_addr_w-1:0]  S_AXI_AWADDR,
   input  logic                               S_AXI_AWVALID,
   output logic                               S_AXI_AWREADY,
   input  logic [aurora_pkg::data_w-1:0]      S_AXI_WDATA,
   input  logic                               S_AXI_WVALID,
   output logic                               S_AXI_WREADY,
   output logic                               S_AXI_BVALID,
   input  logic                               S_AXI_BREADY,
   input  logic [aurora_pkg::axi_addr_w-1:0]  S_AXI_ARADDR,
   input  logic                               S_AXI_ARVALID,
   output logic                               S_AXI_ARREADY,
   output logic [aurora_pkg::data_w-1:0]      S_AXI_RDATA,
   output logic                               S_AXI_RVALID,
   input  logic                               S_AXI_RREADY
);
   import aurora_pkg::*;

   ctrl_t      ctrl;
   axis_beat_t app_tx;        // User frames with trailer
   logic       app_ready;
   axis_beat_t loop_tx;       // Received frames headed back out
   logic       loop_ready;
   logic       fifo_overflow;

   axi_lite_regs axi_lite_regs_inst (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .S_AXI_AWADDR  (S_AXI_AWADDR),
      .S_AXI_AWVALID (S_AXI_AWVALID),
      .S_AXI_AWREADY (S_AXI_AWREADY),
      .S_AXI_WDATA   (S_AXI_WDATA),
      .S_AXI_WVALID  (S_AXI_WVALID),
      .S_AXI_WREADY  (S_AXI_WREADY),
      .S_AXI_BVALID  (S_AXI_BVALID),
      .S_AXI_BREADY  (S_AXI_BREADY),
      .S_AXI_ARADDR  (S_AXI_ARADDR),
      .S_AXI_ARVALID (S_AXI_ARVALID),
      .S_AXI_ARREADY (S_AXI_ARREADY),
      .S_AXI_RDATA   (S_AXI_RDATA),
      .S_AXI_RVALID  (S_AXI_RVALID),
      .S_AXI_RREADY  (S_AXI_RREADY),
      .link_rx       (link_rx),
      .link_tx       (link_tx),
      .link_tx_ready (link_tx_ready),
      .channel_up    (channel_up),
      .fifo_overflow (fifo_overflow),
      .ctrl          (ctrl)
   );

   seq_appender seq_appender_inst (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .s_axis        (s_axis),
      .s_axis_ready  (s_axis_ready),
      .app_tx        (app_tx),
      .app_ready     (app_ready)
   );

   // Receive side, link cannot be stalled
   seq_stripper seq_stripper_inst (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .link_rx       (link_rx),
      .strip_en      (ctrl.strip_en),
      .m_axis        (m_axis)
   );

   loop_fifo loop_fifo_inst (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .wr_en         (ctrl.loopback), // Fill only in loopback mode
      .link_rx       (link_rx),
      .loop_tx       (loop_tx),
      .loop_ready    (loop_ready),
      .fifo_overflow (fifo_overflow)
   );

   tx_path_select tx_path_select_inst (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .loopback      (ctrl.loopback),
      .app_tx        (app_tx),
      .app_ready     (app_ready),
      .loop_tx       (loop_tx),
      .loop_ready    (loop_ready),
      .link_tx       (link_tx),
      .link_tx_ready (link_tx_ready)
   );

endmodule

// File: verification/tb_rtds_aurora_bridge.sv
`timescale 1ns/1ps

module tb_rtds_aurora_bridge;
   import aurora_pkg::*;

   localparam int max_wait = 1000; // Cycle budget of any single wait

   logic                  usr_clk;
   logic                  S_AXI_ARESETN;
   axis_beat_t            s_axis;
   logic                  s_axis_ready;
   axis_beat_t            m_axis;
   axis_beat_t            link_tx;
   logic                  link_tx_ready;
   axis_beat_t            link_rx;
   logic                  channel_up;
   logic [axi_addr_w-1:0] S_AXI_AWADDR;
   logic                  S_AXI_AWVALID;
   logic                  S_AXI_AWREADY;
   logic [data_w-1:0]     S_AXI_WDATA;
   logic                  S_AXI_WVALID;
   logic                  S_AXI_WREADY;
   logic                  S_AXI_BVALID;
   logic                  S_AXI_BREADY;
   logic [axi_addr_w-1:0] S_AXI_ARADDR;
   logic                  S_AXI_ARVALID;
   logic                  S_AXI_ARREADY;
   logic [data_w-1:0]     S_AXI_RDATA;
   logic                  S_AXI_RVALID;
   logic                  S_AXI_RREADY;

   logic [31:0] lfsr_state;
   int          rx_frames; // Frames driven into link_rx
   int          tx_frames; // Frames expected to leave on link_tx

   rtds_aurora_bridge rtds_aurora_bridge_inst (
      .usr_clk       (usr_clk),
      .S_AXI_ARESETN (S_AXI_ARESETN),
      .s_axis        (s_axis),
      .s_axis_ready  (s_axis_ready),
      .m_axis        (m_axis),
      .link_tx       (link_tx),
      .link_tx_ready (link_tx_ready),
      .link_rx       (link_rx),
      .channel_up    (channel_up),
      .S_AXI_AWADDR  (S_AXI_AWADDR),
      .S_AXI_AWVALID (S_AXI_AWVALID),
      .S_AXI_AWREADY (S_AXI_AWREADY),
      .S_AXI_WDATA   (S_AXI_WDATA),
      .S_AXI_WVALID  (S_AXI_WVALID),
      .S_AXI_WREADY  (S_AXI_WREADY),
      .S_AXI_BVALID  (S_AXI_BVALID),
      .S_AXI_BREADY  (S_AXI_BREADY),
      .S_AXI_ARADDR  (S_AXI_ARADDR),
      .S_AXI_ARVALID (S_AXI_ARVALID),
      .S_AXI_ARREADY (S_AXI_ARREADY),
      .S_AXI_RDATA   (S_AXI_RDATA),
      .S_AXI_RVALID  (S_AXI_RVALID),
      .S_AXI_RREADY  (S_AXI_RREADY)
   );

   initial usr_clk = 1'b0;
   always #4 usr_clk = ~usr_clk; // 8 ns period

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] galois_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0]) begin
         n = n ^ 32'h8020_0003;
      end
      return n;
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = galois_step(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic mismatch_stop(input string test, input logic [63:0] expected,
                                input logic [63:0] actual);
      $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", test, expected, actual);
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic error_stop(input string what);
      $display("%s", what);
      $display("Regression failed");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic reg_write(input logic [3:0] word, input logic [31:0] value);
      int waited;
      @(posedge usr_clk);
      S_AXI_AWADDR  <= {word, 2'b00}; // Word address to byte address
      S_AXI_AWVALID <= 1'b1;
      S_AXI_WDATA   <= value;
      S_AXI_WVALID  <= 1'b1;
      S_AXI_BREADY  <= 1'b1;
      waited = 0;
      do begin
         @(posedge usr_clk);
         waited++;
         if (waited > max_wait) begin
            error_stop("Timeout: AWREADY never came for a register write");
         end
      end while (!S_AXI_AWREADY);
      assert (S_AXI_WREADY) else mismatch_stop("reg_write", 1, S_AXI_WREADY);
      S_AXI_AWVALID <= 1'b0;
      S_AXI_WVALID  <= 1'b0;
      waited = 0;
      do begin
         @(posedge usr_clk);
         waited++;
         if (waited > max_wait) begin
            error_stop("Timeout: BVALID never came for a register write");
         end
      end while (!S_AXI_BVALID);
      S_AXI_BREADY <= 1'b0;
   endtask

   task automatic reg_read(input logic [3:0] word, output logic [31:0] value);
      int waited;
      @(posedge usr_clk);
      S_AXI_ARADDR  <= {word, 2'b00};
      S_AXI_ARVALID <= 1'b1;
      S_AXI_RREADY  <= 1'b1; // Taken as soon as RVALID shows
      waited = 0;
      do begin
         @(posedge usr_clk);
         waited++;
         if (waited > max_wait) begin
            error_stop("Timeout: RVALID never came for a register read");
         end
      end while (!S_AXI_RVALID);
      assert (S_AXI_ARREADY) else mismatch_stop("reg_read", 1, S_AXI_ARREADY);
      value = S_AXI_RDATA;
      S_AXI_ARVALID <= 1'b0;
      S_AXI_RREADY  <= 1'b0;
   endtask

   task automatic read_expect(input string test, input logic [3:0] word,
                              input logic [31:0] expected);
      logic [31:0] got;
      reg_read(word, got);
      assert (got == expected) else mismatch_stop(test, expected, got);
   endtask

   task automatic register_access();
      read_expect("register_access", CTRL, 32'd2); // strip_en set, loopback clear
      reg_write(CTRL, 32'd3);
      read_expect("register_access", CTRL, 32'd3);
      reg_write(4'd4, 32'h0000_00fc); // Word 4 is unmapped
      read_expect("register_access", CTRL, 32'd3);
      read_expect("register_access", 4'd4, 32'd0);
      reg_write(CTRL, 32'd2); // Back to user path
   endtask

   task automatic trailer_insertion();
      logic [32:0] src_q[$]; // {data, last} beats from the user
      logic [32:0] exp_q[$]; // {data, last} expected on link_tx
      logic [32:0] got;
      logic [32:0] want;
      logic [31:0] word;
      int          len;
      int          sent;
      int          waited;
      for (int f = 0; f < 5; f++) begin
         len = 1 + take_bits(3) % 6;
         for (int i = 0; i < len; i++) begin
            word = take_bits(32);
            src_q.push_back({word, 1'(i == len - 1)});
            exp_q.push_back({word, 1'b0}); // Last moves to the trailer
         end
         exp_q.push_back({32'(f), 1'b1}); // Trailer carries frame index
      end
      tx_frames += 5;
      sent   = 0;
      waited = 0;
      do begin
         @(posedge usr_clk);
         if (link_tx.valid && link_tx_ready) begin
            got  = {link_tx.data, link_tx.last};
            want = exp_q.pop_front();
            assert (got == want) else mismatch_stop("trailer_insertion", want, got);
         end
         if (s_axis.valid && s_axis_ready) begin
            sent++;
         end
         if (sent < src_q.size()) begin
            s_axis <= {1'b1, src_q[sent]}; // Held until accepted
         end else begin
            s_axis <= '0;
         end
         link_tx_ready <= take_bits(1); // Random back-pressure
         waited++;
         if (waited > max_wait) begin
            error_stop("Timeout: user frames did not all appear on link_tx");
         end
      end while (exp_q.size() > 0);
      link_tx_ready <= 1'b1;
   endtask

   task automatic receive_stripping(input logic strip, input string name);
      logic [32:0] src_q[$];
      logic [32:0] exp_q[$];
      logic [32:0] got;
      logic [32:0] want;
      logic [31:0] word;
      int          len;
      int          sent;
      int          tail;
      int          waited;
      reg_write(CTRL, {30'd0, strip, 1'b0});
      for (int f = 0; f < 4; f++) begin
         len = 1 + take_bits(2); // 1 to 4 words incl. sequence word
         for (int i = 0; i < len; i++) begin
            word = take_bits(32);
            src_q.push_back({word, 1'(i == len - 1)});
            if (!strip) begin
               exp_q.push_back({word, 1'(i == len - 1)});
            end else if (i < len - 1) begin
               exp_q.push_back({word, 1'(i == len - 2)}); // Last word dropped
            end
         end
      end
      rx_frames += 4;
      sent   = 0;
      tail   = 0;
      waited = 0;
      do begin
         @(posedge usr_clk);
         if (m_axis.valid) begin
            got = {m_axis.data, m_axis.last};
            assert (exp_q.size() > 0) else error_stop("Extra beat appeared on m_axis");
            want = exp_q.pop_front();
            assert (got == want) else mismatch_stop(name, want, got);
         end
         if (sent < src_q.size() && take_bits(1)) begin
            link_rx <= {1'b1, src_q[sent]}; // Random gaps between beats
            sent++;
         end else begin
            link_rx <= '0;
         end
         if (sent == src_q.size() && exp_q.size() == 0) begin
            tail++; // Idle cycles to catch stray beats
         end
         waited++;
         if (waited > max_wait) begin
            error_stop("Timeout: received words did not all appear on m_axis");
         end
      end while (tail < 4);
   endtask

   task automatic loopback_path();
      logic [32:0] src_q[$];
      logic [32:0] exp_q[$];
      logic [32:0] got;
      logic [32:0] want;
      int          len;
      int          sent;
      int          waited;
      link_tx_ready <= 1'b1;
      reg_write(CTRL, 32'd3);
      waited = 0;
      do begin
         @(posedge usr_clk);
         waited++;
         if (waited > max_wait) begin
            error_stop("Timeout: s_axis_ready stayed high after loopback was selected");
         end
      end while (s_axis_ready);
      for (int f = 0; f < 3; f++) begin
         len = 1 + take_bits(2);
         for (int i = 0; i < len; i++) begin
            src_q.push_back({take_bits(32), 1'(i == len - 1)});
         end
      end
      exp_q  = src_q; // Returned unchanged, no trailer
      rx_frames += 3;
      tx_frames += 3;
      sent   = 0;
      waited = 0;
      do begin
         @(posedge usr_clk);
         assert (!s_axis_ready) else mismatch_stop("loopback_path", 0, s_axis_ready);
         if (link_tx.valid && link_tx_ready) begin
            got = {link_tx.data, link_tx.last};
            assert (exp_q.size() > 0) else error_stop("Extra beat appeared on link_tx");
            want = exp_q.pop_front();
            assert (got == want) else mismatch_stop("loopback_path", want, got);
         end
         if (sent < src_q.size() && take_bits(1)) begin
            link_rx <= {1'b1, src_q[sent]};
            sent++;
         end else begin
            link_rx <= '0;
         end
         link_tx_ready <= take_bits(1);
         waited++;
         if (waited > max_wait) begin
            error_stop("Timeout: looped frames did not all appear on link_tx");
         end
      end while (sent < src_q.size() || exp_q.size() > 0);
      link_tx_ready <= 1'b1;
   endtask

   task automatic counters_and_status();
      read_expect("counters_and_status", CNTR_IN_L, rx_frames);
      read_expect("counters_and_status", CNTR_IN_H, 32'd0);
      read_expect("counters_and_status", CNTR_OUT_L, tx_frames);
      read_expect("counters_and_status", CNTR_OUT_H, 32'd0);
      read_expect("counters_and_status", STAT, 32'd1); // Link up, no overflow
      channel_up <= 1'b0;
      read_expect("counters_and_status", STAT, 32'd0);
      channel_up <= 1'b1;
      link_tx_ready <= 1'b0; // Nothing drains the FIFO
      for (int i = 0; i < 20; i++) begin
         @(posedge usr_clk);
         link_rx <= {1'b1, take_bits(32), 1'b0};
      end
      @(posedge usr_clk);
      link_rx <= '0;
      read_expect("counters_and_status", STAT, 32'd3); // Overflow is sticky
   endtask

   initial begin
      S_AXI_ARESETN = 1'b0;
      s_axis        = '0;
      link_rx       = '0;
      link_tx_ready = 1'b1;
      channel_up    = 1'b1;
      S_AXI_AWADDR  = '0;
      S_AXI_AWVALID = 1'b0;
      S_AXI_WDATA   = '0;
      S_AXI_WVALID  = 1'b0;
      S_AXI_BREADY  = 1'b0;
      S_AXI_ARADDR  = '0;
      S_AXI_ARVALID = 1'b0;
      S_AXI_RREADY  = 1'b0;
      lfsr_state    = 32'h505d;
      rx_frames     = 0;
      tx_frames     = 0;
      repeat (4) @(posedge usr_clk);
      S_AXI_ARESETN <= 1'b1;
      @(posedge usr_clk);
      assert (s_axis_ready == link_tx_ready && !m_axis.valid && !S_AXI_AWREADY &&
              !S_AXI_WREADY && !S_AXI_BVALID && !S_AXI_ARREADY && !S_AXI_RVALID)
         else error_stop("Outputs were not idle after reset");
      register_access();
      trailer_insertion();
      receive_stripping(1'b1, "receive_stripping on");
      receive_stripping(1'b0, "receive_stripping off");
      loopback_path();
      counters_and_status();
      $display("Regression passed");
      $finish;
   end

endmodule

// File: list.f
src/aurora_pkg.sv
src/axi_lite_regs.sv
src/seq_appender.sv
src/seq_stripper.sv
src/loop_fifo.sv
src/tx_path_select.sv
src/rtds_aurora_bridge.sv
verification/tb_rtds_aurora_bridge.sv
